// File: verilog.f
common/fetch_pkg.sv
icache/itlb.sv
icache/icache_bank.sv
icache/icache.sv
hdl/fip_select.sv
hdl/fetch_1.sv
test/fetch_1_tb.sv

// File: run.sh
#!/bin/sh
# builds the fetch stage testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module fetch_1_tb -o fetch_1_sim
./obj_dir/fetch_1_sim | tee sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    echo "simulation ended without a result, see sim.log"
    exit 1
fi
echo "simulation passed"

// File: test/fetch_1_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_1_tb;

    import fetch_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int RST_CYCLES = 5;
    localparam int MARGIN     = 20;   // spare cycles for the watchdog

    typedef struct packed {
        logic               init;
        logic [VADDR_W-1:0] addr;
        logic               resteer;
        logic               bp;
        fip_t               wb_e;
        fip_t               wb_o;
        fip_t               bp_e;
        fip_t               bp_o;
        logic               ld_e;
        logic               ld_o;
        logic               tlb_wr;
        tlb_idx_t           idx;
        vpn_t               vpn;
        pfn_t               pfn;
        logic               pcd;
        logic               fill_e;
        logic               fill_o;
        pline_t             fpl_e;
        pline_t             fpl_o;
        logic               chk_line;    // line data when a hit is expected
    } step_t;

    logic               clk;
    logic               arst_n_i;
    logic               init_i;
    logic [VADDR_W-1:0] init_addr_i;
    logic               resteer_i;
    logic               bp_taken_i;
    fip_t               wb_fip_even_i, wb_fip_odd_i, bp_fip_even_i, bp_fip_odd_i;
    logic               even_loaded_i, odd_loaded_i;
    logic               tlb_wr_i, tlb_pcd_i;
    tlb_idx_t           tlb_idx_i;
    vpn_t               tlb_vpn_i;
    pfn_t               tlb_pfn_i;
    logic               fill_even_i, fill_odd_i;
    pline_t             fill_pline_even_i, fill_pline_odd_i;
    line_t              fill_line_even_i, fill_line_odd_i;

    // per-bank outputs indexed 0 for even and 1 for odd
    line_t      line_act  [2];
    logic       cmiss_act [2];
    logic       wr_act    [2];
    logic       tmiss_act [2];
    logic       prot_act  [2];
    logic [1:0] lsb_act   [2];
    pline_t     pline_act [2];

    // reference model state
    fip_t  m_fip   [2];
    logic  m_tvld  [TLB_N];
    vpn_t  m_tvpn  [TLB_N];
    pfn_t  m_tpfn  [TLB_N];
    logic  m_tpcd  [TLB_N];
    logic  m_bvld  [2][SETS];
    tag_t  m_btag  [2][SETS];
    line_t m_bdata [2][SETS];

    // expected values of the current step
    fip_t   exp_fip   [2];
    logic   exp_tmiss [2];
    logic   exp_prot  [2];
    logic   exp_hit   [2];
    logic   exp_cmiss [2];
    logic   exp_wr    [2];
    pline_t exp_pline [2];
    line_t  exp_line  [2];

    step_t  steps [$];
    string  names [$];
    integer seed;
    int     checks;
    int     errors;
    int     step_errs;

    fetch_1 UUT (
        .clk (clk), .arst_n_i (arst_n_i),
        .init_i (init_i), .init_addr_i (init_addr_i),
        .resteer_i (resteer_i), .wb_fip_even_i (wb_fip_even_i), .wb_fip_odd_i (wb_fip_odd_i),
        .bp_taken_i (bp_taken_i), .bp_fip_even_i (bp_fip_even_i), .bp_fip_odd_i (bp_fip_odd_i),
        .even_loaded_i (even_loaded_i), .odd_loaded_i (odd_loaded_i),
        .tlb_wr_i (tlb_wr_i), .tlb_idx_i (tlb_idx_i), .tlb_vpn_i (tlb_vpn_i),
        .tlb_pfn_i (tlb_pfn_i), .tlb_pcd_i (tlb_pcd_i),
        .fill_even_i (fill_even_i), .fill_odd_i (fill_odd_i),
        .fill_pline_even_i (fill_pline_even_i), .fill_pline_odd_i (fill_pline_odd_i),
        .fill_line_even_i (fill_line_even_i), .fill_line_odd_i (fill_line_odd_i),
        .line_even_o (line_act[0]), .line_odd_o (line_act[1]),
        .cache_miss_even_o (cmiss_act[0]), .cache_miss_odd_o (cmiss_act[1]),
        .writing_even_o (wr_act[0]), .writing_odd_o (wr_act[1]),
        .tlb_miss_even_o (tmiss_act[0]), .tlb_miss_odd_o (tmiss_act[1]),
        .prot_fault_even_o (prot_act[0]), .prot_fault_odd_o (prot_act[1]),
        .fip_even_lsb_o (lsb_act[0]), .fip_odd_lsb_o (lsb_act[1]),
        .refill_pline_even_o (pline_act[0]), .refill_pline_odd_o (pline_act[1])
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic fip_t select_fip(input logic odd, input step_t s);
        fip_t init_line;
        init_line = fip_t'(s.addr >> 4);
        if (s.init) begin
            // the bank whose parity matches takes the init line
            return (init_line[0] == odd) ? init_line : init_line + fip_t'(1);
        end else if (s.resteer) begin
            return odd ? s.wb_o : s.wb_e;
        end else if (s.bp) begin
            return odd ? s.bp_o : s.bp_e;
        end
        return m_fip[odd];
    endfunction

    task automatic predict(input step_t s);
        vpn_t v;
        pfn_t f;
        logic found;
        set_t st;
        for (int b = 0; b < 2; b++) begin
            exp_fip[b]  = select_fip(b[0], s);
            v           = exp_fip[b][27:8];
            found       = 1'b0;
            f           = '0;
            exp_prot[b] = 1'b0;
            for (int i = 0; i < TLB_N; i++) begin
                if (!found && m_tvld[i] && m_tvpn[i] == v) begin   // lowest index wins
                    found       = 1'b1;
                    f           = m_tpfn[i];
                    exp_prot[b] = m_tpcd[i];
                end
            end
            exp_tmiss[b] = !found;
            exp_pline[b] = {f[2:0], exp_fip[b][7:0]};
            st           = exp_pline[b][3:0];
            exp_hit[b]   = m_bvld[b][st] && m_btag[b][st] == exp_pline[b][10:4];
            exp_cmiss[b] = found && !exp_prot[b] && !exp_hit[b];
            exp_line[b]  = m_bdata[b][st];
            exp_wr[b]    = (b == 0) ? s.fill_e : s.fill_o;
        end
    endtask

    task automatic store_line(input int b, input pline_t pl, input line_t data);
        m_bvld[b][pl[3:0]]  = 1'b1;
        m_btag[b][pl[3:0]]  = pl[10:4];
        m_bdata[b][pl[3:0]] = data;
    endtask

    // state after the clock edge of a step
    task automatic advance(input step_t s);
        if (s.ld_e) begin
            m_fip[0] = exp_fip[0] + fip_t'(2);
        end
        if (s.ld_o) begin
            m_fip[1] = exp_fip[1] + fip_t'(2);
        end
        if (s.tlb_wr) begin
            m_tvld[s.idx] = 1'b1;
            m_tvpn[s.idx] = s.vpn;
            m_tpfn[s.idx] = s.pfn;
            m_tpcd[s.idx] = s.pcd;
        end
        if (s.fill_e) begin
            store_line(0, s.fpl_e, fill_line_even_i);
        end
        if (s.fill_o) begin
            store_line(1, s.fpl_o, fill_line_odd_i);
        end
    endtask

    //////////////////////////////
    // drive and compare
    //////////////////////////////

    task automatic apply(input step_t s);
        init_i            = s.init;
        init_addr_i       = s.addr;
        resteer_i         = s.resteer;
        bp_taken_i        = s.bp;
        wb_fip_even_i     = s.wb_e;
        wb_fip_odd_i      = s.wb_o;
        bp_fip_even_i     = s.bp_e;
        bp_fip_odd_i      = s.bp_o;
        even_loaded_i     = s.ld_e;
        odd_loaded_i      = s.ld_o;
        tlb_wr_i          = s.tlb_wr;
        tlb_idx_i         = s.idx;
        tlb_vpn_i         = s.vpn;
        tlb_pfn_i         = s.pfn;
        tlb_pcd_i         = s.pcd;
        fill_even_i       = s.fill_e;
        fill_odd_i        = s.fill_o;
        fill_pline_even_i = s.fpl_e;
        fill_pline_odd_i  = s.fpl_o;
        fill_line_even_i  = {$random(seed), $random(seed), $random(seed), $random(seed)};
        fill_line_odd_i   = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    task automatic check(input string nm, input string what, input line_t exp, input line_t act);
        checks++;
        assert (act === exp) else begin
            $display("ERROR %s: %s expected %0h actual %0h", nm, what, exp, act);
            errors++;
            step_errs++;
        end
    endtask

    task automatic compare(input string nm, input step_t s);
        string bank;
        for (int b = 0; b < 2; b++) begin
            bank = (b == 0) ? "even" : "odd";
            check(nm, {"fip_lsb ", bank}, line_t'(exp_fip[b][1:0]), line_t'(lsb_act[b]));
            if (!exp_tmiss[b]) begin   // frame is unknown without a mapping
                check(nm, {"refill_pline ", bank}, line_t'(exp_pline[b]), line_t'(pline_act[b]));
            end
            check(nm, {"tlb_miss ", bank}, line_t'(exp_tmiss[b]), line_t'(tmiss_act[b]));
            check(nm, {"prot_fault ", bank}, line_t'(exp_prot[b]), line_t'(prot_act[b]));
            check(nm, {"cache_miss ", bank}, line_t'(exp_cmiss[b]), line_t'(cmiss_act[b]));
            check(nm, {"writing ", bank}, line_t'(exp_wr[b]), line_t'(wr_act[b]));
            if (s.chk_line && exp_hit[b] && !exp_tmiss[b] && !exp_prot[b] && !exp_wr[b]) begin
                check(nm, {"line ", bank}, exp_line[b], line_act[b]);
            end
        end
    endtask

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    function automatic step_t blank();
        return '0;
    endfunction

    task automatic add_step(input string nm, input step_t s);
        names.push_back(nm);
        steps.push_back(s);
    endtask

    task automatic build_table();
        step_t s;
        s = blank();
        add_step("reset state", s);
        s        = blank();
        s.tlb_wr = 1'b1;
        s.idx    = 3'd0;
        s.vpn    = 20'h0;
        s.pfn    = 20'h5;
        add_step("map page 0", s);
        s        = blank();
        s.tlb_wr = 1'b1;
        s.idx    = 3'd1;
        s.vpn    = 20'h1;
        s.pfn    = 20'h6;
        s.pcd    = 1'b1;
        add_step("map page 1 uncached", s);
        s        = blank();
        s.tlb_wr = 1'b1;
        s.idx    = 3'd2;
        s.vpn    = 20'h2;
        s.pfn    = 20'h3;
        add_step("map page 2", s);
        s        = blank();
        s.tlb_wr = 1'b1;
        s.idx    = 3'd5;
        s.vpn    = 20'h2;
        s.pfn    = 20'h7;
        add_step("page 2 again at higher index", s);
        s      = blank();
        s.init = 1'b1;
        s.addr = 32'h0000_0040;
        s.ld_e = 1'b1;
        s.ld_o = 1'b1;
        add_step("init even line", s);
        s      = blank();
        s.ld_e = 1'b1;
        add_step("even advances odd holds", s);
        s = blank();
        add_step("both hold", s);
        s      = blank();
        s.init = 1'b1;
        s.addr = 32'h0000_0153;
        s.ld_e = 1'b1;
        s.ld_o = 1'b1;
        add_step("init odd line", s);
        s         = blank();
        s.init    = 1'b1;
        s.resteer = 1'b1;
        s.bp      = 1'b1;
        s.addr    = 32'h0000_0200;
        s.wb_e    = 28'h32;
        s.wb_o    = 28'h43;
        s.bp_e    = 28'h51;
        s.bp_o    = 28'h60;
        add_step("init beats resteer and bp", s);
        s.init = 1'b0;
        add_step("resteer beats bp", s);
        s.resteer = 1'b0;
        add_step("bp alone", s);
        s         = blank();
        s.resteer = 1'b1;
        s.wb_e    = 28'h100;
        s.wb_o    = 28'h301;
        add_step("uncached and unmapped pages", s);
        s         = blank();
        s.resteer = 1'b1;
        s.wb_e    = 28'h12;
        s.wb_o    = 28'h213;
        add_step("first access misses", s);
        s.fill_e = 1'b1;
        s.fill_o = 1'b1;
        s.fpl_e  = 11'h512;
        s.fpl_o  = 11'h313;
        add_step("fill shows writing", s);
        s.fill_e   = 1'b0;
        s.fill_o   = 1'b0;
        s.chk_line = 1'b1;
        add_step("hit returns filled line", s);
        s.wb_e = 28'h212;
        s.wb_o = 28'h13;
        add_step("other tag same set misses", s);
        s.wb_e = 28'h12;
        s.wb_o = 28'h213;
        s.ld_e = 1'b1;
        s.ld_o = 1'b1;
        add_step("load from resteer", s);
        s          = blank();
        s.chk_line = 1'b1;
        add_step("pointers two lines on", s);
    endtask

    //////////////////////////////
    // main flow
    //////////////////////////////

    initial begin
        seed   = 32'h6bcc8c4b;
        checks = 0;
        errors = 0;
        apply('0);
        for (int b = 0; b < 2; b++) begin
            m_fip[b] = '0;
            for (int i = 0; i < SETS; i++) begin
                m_bvld[b][i] = 1'b0;
            end
        end
        for (int i = 0; i < TLB_N; i++) begin
            m_tvld[i] = 1'b0;
        end
        build_table();
        arst_n_i = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 arst_n_i = 1'b1;
        foreach (steps[i]) begin
            apply(steps[i]);
            predict(steps[i]);
            #8;                       // just before the next edge
            step_errs = 0;
            compare(names[i], steps[i]);
            if (step_errs == 0) begin
                $display("step %0d %s: ok", i, names[i]);
            end else begin
                $display("step %0d %s: %0d mismatches", i, names[i], step_errs);
            end
            @(posedge clk);
            advance(steps[i]);
            #1;
        end
        $display("%0d steps, %0d checks, %0d errors", steps.size(), checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // starts 1 ns late so the table is already built
    initial begin
        #1;
        #((steps.size() + RST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("watchdog: run did not finish within the expected number of cycles");
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/fetch_1.sv
`default_nettype none
`timescale 1ns/1ns

module fetch_1 (
    input  wire                clk,
    input  wire                arst_n_i,

    input  wire                init_i,
    input  wire [fetch_pkg::VADDR_W-1:0] init_addr_i,
    input  wire                resteer_i,
    input  wire fetch_pkg::fip_t wb_fip_even_i,
    input  wire fetch_pkg::fip_t wb_fip_odd_i,
    input  wire                bp_taken_i,
    input  wire fetch_pkg::fip_t bp_fip_even_i,
    input  wire fetch_pkg::fip_t bp_fip_odd_i,

    input  wire                even_loaded_i,
    input  wire                odd_loaded_i,

    input  wire                tlb_wr_i,
    input  wire fetch_pkg::tlb_idx_t tlb_idx_i,
    input  wire fetch_pkg::vpn_t tlb_vpn_i,
    input  wire fetch_pkg::pfn_t tlb_pfn_i,
    input  wire                tlb_pcd_i,

    input  wire                fill_even_i,
    input  wire                fill_odd_i,
    input  wire fetch_pkg::pline_t fill_pline_even_i,
    input  wire fetch_pkg::pline_t fill_pline_odd_i,
    input  wire fetch_pkg::line_t fill_line_even_i,
    input  wire fetch_pkg::line_t fill_line_odd_i,

    output fetch_pkg::line_t   line_even_o,
    output fetch_pkg::line_t   line_odd_o,
    output logic               cache_miss_even_o,
    output logic               cache_miss_odd_o,
    output logic               writing_even_o,   // line_even_o not valid while high
    output logic               writing_odd_o,
    output logic               tlb_miss_even_o,
    output logic               tlb_miss_odd_o,
    output logic               prot_fault_even_o,
    output logic               prot_fault_odd_o,
    output logic [1:0]         fip_even_lsb_o,
    output logic [1:0]         fip_odd_lsb_o,
    output fetch_pkg::pline_t  refill_pline_even_o,
    output fetch_pkg::pline_t  refill_pline_odd_o
);

    import fetch_pkg::*;

    fip_t init_line;
    fip_t init_line_p1;
    fip_t init_fip_even;
    fip_t init_fip_odd;
    fip_t fip_even;
    fip_t fip_odd;

    //////////////////////////////
    // init split across banks
    //////////////////////////////

    assign init_line    = init_addr_i[VADDR_W-1:LINE_OFF_W];
    assign init_line_p1 = init_line + fip_t'(1);

    // the bank that owns the init line takes it, the other one starts a line later
    always_comb begin
        if (!init_line[0]) begin
            init_fip_even = init_line;
            init_fip_odd  = init_line_p1;
        end else begin
            init_fip_even = init_line_p1;
            init_fip_odd  = init_line;
        end
    end

    fip_select sel_even (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .init_i     (init_i),
        .resteer_i  (resteer_i),
        .bp_taken_i (bp_taken_i),
        .init_fip_i (init_fip_even),
        .wb_fip_i   (wb_fip_even_i),
        .bp_fip_i   (bp_fip_even_i),
        .loaded_i   (even_loaded_i),
        .fip_o      (fip_even)
    );

    fip_select sel_odd (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .init_i     (init_i),
        .resteer_i  (resteer_i),
        .bp_taken_i (bp_taken_i),
        .init_fip_i (init_fip_odd),
        .wb_fip_i   (wb_fip_odd_i),
        .bp_fip_i   (bp_fip_odd_i),
        .loaded_i   (odd_loaded_i),
        .fip_o      (fip_odd)
    );

    assign fip_even_lsb_o = fip_even[1:0];
    assign fip_odd_lsb_o  = fip_odd[1:0];

    icache icache (
        .clk                 (clk),
        .arst_n_i            (arst_n_i),
        .fip_even_i          (fip_even),
        .fip_odd_i           (fip_odd),
        .tlb_wr_i            (tlb_wr_i),
        .tlb_idx_i           (tlb_idx_i),
        .tlb_vpn_i           (tlb_vpn_i),
        .tlb_pfn_i           (tlb_pfn_i),
        .tlb_pcd_i           (tlb_pcd_i),
        .fill_even_i         (fill_even_i),
        .fill_pline_even_i   (fill_pline_even_i),
        .fill_line_even_i    (fill_line_even_i),
        .fill_odd_i          (fill_odd_i),
        .fill_pline_odd_i    (fill_pline_odd_i),
        .fill_line_odd_i     (fill_line_odd_i),
        .line_even_o         (line_even_o),
        .line_odd_o          (line_odd_o),
        .cache_miss_even_o   (cache_miss_even_o),
        .cache_miss_odd_o    (cache_miss_odd_o),
        .writing_even_o      (writing_even_o),
        .writing_odd_o       (writing_odd_o),
        .tlb_miss_even_o     (tlb_miss_even_o),
        .tlb_miss_odd_o      (tlb_miss_odd_o),
        .prot_fault_even_o   (prot_fault_even_o),
        .prot_fault_odd_o    (prot_fault_odd_o),
        .refill_pline_even_o (refill_pline_even_o),
        .refill_pline_odd_o  (refill_pline_odd_o)
    );

endmodule

`default_nettype wire

// File: hdl/fip_select.sv
`default_nettype none
`timescale 1ns/1ns

module fip_select (
    input  wire              clk,
    input  wire              arst_n_i,
    input  wire              init_i,
    input  wire              resteer_i,
    input  wire              bp_taken_i,
    input  wire fetch_pkg::fip_t init_fip_i,
    input  wire fetch_pkg::fip_t wb_fip_i,
    input  wire fetch_pkg::fip_t bp_fip_i,
    input  wire              loaded_i,
    output fetch_pkg::fip_t  fip_o
);

    import fetch_pkg::*;

    fip_t cf_fip;   // winning control-flow target
    fip_t fip_q;    // sequential pointer
    logic is_cf;

    //////////////////////////////
    // control-flow priority
    //////////////////////////////

    assign is_cf = init_i | resteer_i | bp_taken_i;

    always_comb begin
        if (init_i) begin
            cf_fip = init_fip_i;        // init beats everything
        end else if (resteer_i) begin
            cf_fip = wb_fip_i;          // write-back resteer
        end else begin
            cf_fip = bp_fip_i;
        end
    end

    assign fip_o = is_cf ? cf_fip : fip_q;

    //////////////////////////////
    // sequential pointer
    //////////////////////////////

    // next line of this bank is two lines on, the other bank owns the one between
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fip_q <= '0;
        end else if (loaded_i) begin
            fip_q <= fip_o + fip_t'(2);
        end
    end

endmodule

`default_nettype wire

// File: icache/icache.sv
`default_nettype none
`timescale 1ns/1ns

module icache (
    input  wire                clk,
    input  wire                arst_n_i,
    input  wire fetch_pkg::fip_t fip_even_i,
    input  wire fetch_pkg::fip_t fip_odd_i,

    input  wire                tlb_wr_i,
    input  wire fetch_pkg::tlb_idx_t tlb_idx_i,
    input  wire fetch_pkg::vpn_t tlb_vpn_i,
    input  wire fetch_pkg::pfn_t tlb_pfn_i,
    input  wire                tlb_pcd_i,

    input  wire                fill_even_i,
    input  wire fetch_pkg::pline_t fill_pline_even_i,
    input  wire fetch_pkg::line_t fill_line_even_i,
    input  wire                fill_odd_i,
    input  wire fetch_pkg::pline_t fill_pline_odd_i,
    input  wire fetch_pkg::line_t fill_line_odd_i,

    output fetch_pkg::line_t   line_even_o,
    output fetch_pkg::line_t   line_odd_o,
    output logic               cache_miss_even_o,
    output logic               cache_miss_odd_o,
    output logic               writing_even_o,
    output logic               writing_odd_o,
    output logic               tlb_miss_even_o,
    output logic               tlb_miss_odd_o,
    output logic               prot_fault_even_o,
    output logic               prot_fault_odd_o,
    output fetch_pkg::pline_t  refill_pline_even_o,
    output fetch_pkg::pline_t  refill_pline_odd_o
);

    import fetch_pkg::*;

    vpn_t   vpn_even, vpn_odd;
    pfn_t   pfn_even, pfn_odd;
    pline_t pline_even, pline_odd;

    // page number goes to the tlb, line-in-page passes straight through
    assign vpn_even = fip_even_i[FIP_W-1:PG_LINE_W];
    assign vpn_odd  = fip_odd_i[FIP_W-1:PG_LINE_W];

    itlb tlb (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wr_i     (tlb_wr_i),
        .wr_idx_i (tlb_idx_i),
        .wr_vpn_i (tlb_vpn_i),
        .wr_pfn_i (tlb_pfn_i),
        .wr_pcd_i (tlb_pcd_i),
        .vpn_a_i  (vpn_even),
        .vpn_b_i  (vpn_odd),
        .pfn_a_o  (pfn_even),
        .miss_a_o (tlb_miss_even_o),
        .prot_a_o (prot_fault_even_o),
        .pfn_b_o  (pfn_odd),
        .miss_b_o (tlb_miss_odd_o),
        .prot_b_o (prot_fault_odd_o)
    );

    // only the low frame bits are backed by memory
    assign pline_even = {pfn_even[FRAME_W-1:0], fip_even_i[PG_LINE_W-1:0]};
    assign pline_odd  = {pfn_odd[FRAME_W-1:0], fip_odd_i[PG_LINE_W-1:0]};

    icache_bank bank_even (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .pline_i        (pline_even),
        .xlate_bad_i    (tlb_miss_even_o | prot_fault_even_o),
        .fill_i         (fill_even_i),
        .fill_pline_i   (fill_pline_even_i),
        .fill_line_i    (fill_line_even_i),
        .line_o         (line_even_o),
        .miss_o         (cache_miss_even_o),
        .writing_o      (writing_even_o),
        .refill_pline_o (refill_pline_even_o)
    );

    icache_bank bank_odd (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .pline_i        (pline_odd),
        .xlate_bad_i    (tlb_miss_odd_o | prot_fault_odd_o),
        .fill_i         (fill_odd_i),
        .fill_pline_i   (fill_pline_odd_i),
        .fill_line_i    (fill_line_odd_i),
        .line_o         (line_odd_o),
        .miss_o         (cache_miss_odd_o),
        .writing_o      (writing_odd_o),
        .refill_pline_o (refill_pline_odd_o)
    );

endmodule

`default_nettype wire

// File: icache/icache_bank.sv
`default_nettype none
`timescale 1ns/1ns

module icache_bank (
    input  wire                  clk,
    input  wire                  arst_n_i,
    input  wire fetch_pkg::pline_t pline_i,      // translated line to look up
    input  wire                  xlate_bad_i,    // tlb miss or prot fault
    input  wire                  fill_i,
    input  wire fetch_pkg::pline_t fill_pline_i,
    input  wire fetch_pkg::line_t fill_line_i,
    output fetch_pkg::line_t     line_o,
    output logic                 miss_o,
    output logic                 writing_o,
    output fetch_pkg::pline_t    refill_pline_o
);

    import fetch_pkg::*;

    //////////////////////////////
    // storage
    //////////////////////////////

    logic [SETS-1:0] vld_q;
    tag_t            tag_q  [SETS];
    line_t           data_q [SETS];

    set_t rd_set;
    tag_t rd_tag;
    set_t wr_set;
    tag_t wr_tag;
    logic tag_hit;

    // index is the low bits, tag whatever is left above
    assign rd_set = pline_i[SET_W-1:0];
    assign rd_tag = pline_i[PLINE_W-1:SET_W];
    assign wr_set = fill_pline_i[SET_W-1:0];
    assign wr_tag = fill_pline_i[PLINE_W-1:SET_W];

    //////////////////////////////
    // read side
    //////////////////////////////

    always_comb begin
        tag_hit = vld_q[rd_set] && (tag_q[rd_set] == rd_tag);
        // nothing to refill when translation failed
        miss_o  = !xlate_bad_i && !tag_hit;
    end

    assign line_o         = data_q[rd_set];
    assign refill_pline_o = pline_i;  // memory side fetches this line on a miss

    //////////////////////////////
    // refill
    //////////////////////////////

    // line is written on this edge, output of this cycle is stale
    assign writing_o = fill_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld_q <= '0;
        end else if (fill_i) begin
            vld_q[wr_set] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q[wr_set]  <= wr_tag;
            data_q[wr_set] <= fill_line_i;
        end
    end

endmodule

`default_nettype wire

// File: icache/itlb.sv
`default_nettype none
`timescale 1ns/1ns

module itlb (
    input  wire                clk,
    input  wire                arst_n_i,
    input  wire                wr_i,
    input  wire fetch_pkg::tlb_idx_t wr_idx_i,
    input  wire fetch_pkg::vpn_t wr_vpn_i,
    input  wire fetch_pkg::pfn_t wr_pfn_i,
    input  wire                wr_pcd_i,
    input  wire fetch_pkg::vpn_t vpn_a_i,
    input  wire fetch_pkg::vpn_t vpn_b_i,
    output fetch_pkg::pfn_t    pfn_a_o,
    output logic               miss_a_o,
    output logic               prot_a_o,
    output fetch_pkg::pfn_t    pfn_b_o,
    output logic               miss_b_o,
    output logic               prot_b_o
);

    import fetch_pkg::*;

    logic [TLB_N-1:0] vld_q;
    logic [TLB_N-1:0] pcd_q;    // uncached i/o page that cannot be fetched
    vpn_t             vpn_q [TLB_N];
    pfn_t             pfn_q [TLB_N];

    vpn_t     look_vpn [2];     // port a is even and port b is odd
    logic     hit      [2];
    tlb_idx_t hit_idx  [2];

    //////////////////////////////
    // entry write
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld_q <= '0;
        end else if (wr_i) begin
            vld_q[wr_idx_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i) begin
            vpn_q[wr_idx_i] <= wr_vpn_i;
            pfn_q[wr_idx_i] <= wr_pfn_i;
            pcd_q[wr_idx_i] <= wr_pcd_i;
        end
    end

    //////////////////////////////
    // lookup, both ports
    //////////////////////////////

    assign look_vpn[0] = vpn_a_i;
    assign look_vpn[1] = vpn_b_i;

    // scan top down so the lowest matching entry is the one kept
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            hit[p]     = 1'b0;
            hit_idx[p] = '0;
            for (int i = TLB_N - 1; i >= 0; i--) begin
                if (vld_q[i] && (vpn_q[i] == look_vpn[p])) begin
                    hit[p]     = 1'b1;
                    hit_idx[p] = tlb_idx_t'(i);
                end
            end
        end
    end

    assign pfn_a_o  = pfn_q[hit_idx[0]];
    assign miss_a_o = !hit[0];
    assign prot_a_o = hit[0] & pcd_q[hit_idx[0]];

    assign pfn_b_o  = pfn_q[hit_idx[1]];
    assign miss_b_o = !hit[1];
    assign prot_b_o = hit[1] & pcd_q[hit_idx[1]];

endmodule

`default_nettype wire

// File: common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    //////////////////////////////
    // virtual side
    //////////////////////////////

    localparam int VADDR_W    = 32;                    // byte address from init
    localparam int LINE_OFF_W = 4;                     // 16 byte lines
    localparam int FIP_W      = VADDR_W - LINE_OFF_W;  // line address
    localparam int LINE_W     = 128;

    localparam int PAGE_OFF_W = 12;                    // 4k pages
    localparam int PG_LINE_W  = PAGE_OFF_W - LINE_OFF_W; // line number inside a page
    localparam int VPN_W      = 20;

    //////////////////////////////
    // physical side
    //////////////////////////////

    localparam int PFN_W      = 20;
    localparam int PADDR_W    = 15;
    localparam int FRAME_W    = PADDR_W - PAGE_OFF_W;  // frame bits actually backed
    localparam int PLINE_W    = PADDR_W - LINE_OFF_W;

    // direct mapped banks
    localparam int SET_W      = 4;
    localparam int SETS       = 1 << SET_W;
    localparam int TAG_W      = PLINE_W - SET_W;

    // itlb
    localparam int TLB_N      = 8;
    localparam int TLB_IDX_W  = 3;

    typedef logic [FIP_W-1:0]     fip_t;
    typedef logic [LINE_W-1:0]    line_t;
    typedef logic [VPN_W-1:0]     vpn_t;
    typedef logic [PFN_W-1:0]     pfn_t;
    typedef logic [PLINE_W-1:0]   pline_t;
    typedef logic [SET_W-1:0]     set_t;
    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [TLB_IDX_W-1:0] tlb_idx_t;

endpackage

`default_nettype wire
